//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_decode_execute
FILELIST  = build.f
LOG       = sim.log

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
+incdir+include
hw/or_isa_pkg.sv
hw/dx_pipe_pkg.sv
hw/hazard_detect.sv
hw/branch_resolve.sv
hw/stage_register.sv
hw/decode_execute.sv
test/dx_assertions.sv
test/tb_decode_execute.sv

//--- hw/branch_resolve.sv
// branch resolution in decode: taken, target, mispredict target, link value, alignment
`timescale 1ns/100ps
`default_nettype none

`include "dx_cfg.svh"

module branch_resolve (
   input  or_isa_pkg::addr_t          pc_i,
   input  dx_pipe_pkg::dec_op_t       dec_op_i,
   input  dx_pipe_pkg::dec_operand_t  dec_operand_i,
   input  logic                       predicted_flag_i,
   input  or_isa_pkg::addr_t          decode_rfb_i,
   input  or_isa_pkg::addr_t          execute_rfb_i,
   input  logic                       exec_jr_i,
   input  logic                       exec_bubble_i,
   input  logic                       jr_pending_i,
   input  logic                       flush_i,
   output dx_pipe_pkg::branch_res_t   res_o
);

   import or_isa_pkg::*;

   // offset field is 26 bits of words, i.e. 28 bits of bytes
   localparam int unsigned SEXT_W = `DX_OPERAND_WIDTH - 28;
   localparam addr_t PC_STEP = (`DX_DELAY_SLOT != 0) ? addr_t'(8) : addr_t'(4);

   addr_t imm_offset;
   addr_t imm_target;
   addr_t reg_target;
   addr_t target;
   addr_t next_pc;
   logic  imm_taken;
   logic  reg_taken;
   logic  taken;
   logic  mispredicted_dir;

   assign imm_offset = {{SEXT_W{dec_operand_i.immjbr_upper[9]}},
                        dec_operand_i.immjbr_upper,
                        dec_operand_i.imm16,
                        2'b00};

   assign imm_target = pc_i + imm_offset;

   // l.j and l.jal have opcode bits 2:1 clear, l.bf/l.bnf compare bit 2 to the flag
   assign imm_taken = dec_op_i.jbr &
                      (~|dec_operand_i.opc_insn[2:1] |
                       (dec_operand_i.opc_insn[2] == predicted_flag_i));

   assign reg_taken = dec_op_i.jr & ~jr_pending_i;

   // after the bubble the producer has moved on, so the value sits in the
   // execute-stage operand instead of the register file read
   assign reg_target = (exec_bubble_i | exec_jr_i) ? execute_rfb_i : decode_rfb_i;

   assign target = imm_taken ? imm_target : reg_target;
   assign taken  = (imm_taken | reg_taken) & ~flush_i;

   assign next_pc = pc_i + PC_STEP;

   // the branch went the opposite way of the prediction
   assign mispredicted_dir = (dec_op_i.bf & ~predicted_flag_i) |
                             (dec_op_i.bnf & predicted_flag_i);

   always_comb begin
      res_o.taken             = taken;
      res_o.target            = target;
      res_o.mispredict_target = mispredicted_dir ? imm_target : next_pc;
      res_o.jal_result        = next_pc;
      res_o.ibus_align        = taken & (|target[`DX_INSN_ALIGN_BITS-1:0]);
   end

endmodule

`default_nettype wire

//--- hw/decode_execute.sv
// decode-to-execute stage: hazard detection, branch resolution and the stage register
`timescale 1ns/100ps
`default_nettype none

module decode_execute (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       padv_i,
   input  logic                       pipeline_flush_i,
   input  or_isa_pkg::addr_t          pc_decode_i,
   input  dx_pipe_pkg::dec_op_t       decode_op_i,
   input  dx_pipe_pkg::dec_operand_t  decode_operand_i,
   input  logic                       decode_op_rfe_i,
   input  logic                       decode_except_illegal_i,
   input  logic                       decode_except_syscall_i,
   input  or_isa_pkg::addr_t          decode_rfb_i,
   input  or_isa_pkg::addr_t          execute_rfb_i,
   input  logic                       predicted_flag_i,
   input  dx_pipe_pkg::ctrl_stage_t   ctrl_stage_i,
   output dx_pipe_pkg::dec_op_t       execute_op_o,
   output dx_pipe_pkg::dec_operand_t  execute_operand_o,
   output logic                       execute_op_rfe_o,
   output logic                       execute_except_illegal_o,
   output logic                       execute_except_syscall_o,
   output logic                       execute_except_ibus_align_o,
   output or_isa_pkg::addr_t          pc_execute_o,
   output or_isa_pkg::addr_t          execute_mispredict_target_o,
   output logic                       execute_predicted_flag_o,
   output or_isa_pkg::addr_t          execute_jal_result_o,
   output logic                       decode_valid_o,
   output logic                       execute_bubble_o,
   output logic                       decode_branch_o,
   output or_isa_pkg::addr_t          decode_branch_target_o,
   output logic                       decode_bubble_o
);

   import dx_pipe_pkg::*;

   logic         jr_pending;
   branch_res_t  branch_res;
   except_t      decode_except;
   except_t      execute_except;

   // no alignment fault is known before the branch is resolved
   assign decode_except = '{illegal:    decode_except_illegal_i,
                            syscall:    decode_except_syscall_i,
                            ibus_align: 1'b0};

   hazard_detect u_hazard (
      .dec_op_i        (decode_op_i),
      .dec_operand_i   (decode_operand_i),
      .op_rfe_i        (decode_op_rfe_i),
      .ctrl_i          (ctrl_stage_i),
      .exec_op_i       (execute_op_o),
      .exec_rf_wb_i    (execute_operand_o.rf_wb),
      .exec_rfd_adr_i  (execute_operand_o.rfd_adr),
      .padv_i          (padv_i),
      .decode_bubble_o (decode_bubble_o),
      .jr_pending_o    (jr_pending)
   );

   branch_resolve u_branch (
      .pc_i             (pc_decode_i),
      .dec_op_i         (decode_op_i),
      .dec_operand_i    (decode_operand_i),
      .predicted_flag_i (predicted_flag_i),
      .decode_rfb_i     (decode_rfb_i),
      .execute_rfb_i    (execute_rfb_i),
      .exec_jr_i        (execute_op_o.jr),
      .exec_bubble_i    (execute_bubble_o),
      .jr_pending_i     (jr_pending),
      .flush_i          (pipeline_flush_i),
      .res_o            (branch_res)
   );

   stage_register u_stage (
      .clk                 (clk),
      .rst                 (rst),
      .padv_i              (padv_i),
      .flush_i             (pipeline_flush_i),
      .pc_i                (pc_decode_i),
      .dec_op_i            (decode_op_i),
      .dec_operand_i       (decode_operand_i),
      .except_i            (decode_except),
      .op_rfe_i            (decode_op_rfe_i),
      .decode_bubble_i     (decode_bubble_o),
      .branch_i            (branch_res),
      .predicted_flag_i    (predicted_flag_i),
      .exec_op_o           (execute_op_o),
      .exec_operand_o      (execute_operand_o),
      .exec_except_o       (execute_except),
      .exec_op_rfe_o       (execute_op_rfe_o),
      .pc_execute_o        (pc_execute_o),
      .mispredict_target_o (execute_mispredict_target_o),
      .predicted_flag_o    (execute_predicted_flag_o),
      .jal_result_o        (execute_jal_result_o),
      .decode_valid_o      (decode_valid_o),
      .execute_bubble_o    (execute_bubble_o)
   );

   assign decode_branch_o        = branch_res.taken;
   assign decode_branch_target_o = branch_res.target;

   assign execute_except_illegal_o    = execute_except.illegal;
   assign execute_except_syscall_o    = execute_except.syscall;
   assign execute_except_ibus_align_o = execute_except.ibus_align;

endmodule

`default_nettype wire

//--- hw/dx_pipe_pkg.sv
// pipeline bundles passed from decode into execute and between the stage blocks
`default_nettype none

package dx_pipe_pkg;

   import or_isa_pkg::*;

   // one-hot style operation flags from the decoder
   typedef struct packed {
      logic alu;
      logic add;
      logic mul;
      logic setflag;
      logic jbr;
      logic jr;
      logic jal;
      logic bf;
      logic bnf;
      logic brcond;
      logic branch;
      logic lsu_load;
      logic lsu_store;
      logic lsu_atomic;
      logic mfspr;
      logic mtspr;
   } dec_op_t;

   // operand selects and fields of the decoded instruction
   typedef struct packed {
      rf_adr_t       rfd_adr;
      rf_adr_t       rfa_adr;
      rf_adr_t       rfb_adr;
      imm16_t        imm16;
      immjbr_upper_t immjbr_upper;
      addr_t         immediate;
      logic          immediate_sel;
      alu_opc_t      opc_alu;
      alu_opc_t      opc_alu_secondary;
      opc_insn_t     opc_insn;
      logic          adder_do_sub;
      logic          adder_do_carry;
      lsu_len_t      lsu_length;
      logic          lsu_zext;
      logic          rf_wb;
   } dec_operand_t;

   typedef struct packed {
      logic illegal;
      logic syscall;
      logic ibus_align;
   } except_t;

   // what the control stage is about to write back
   typedef struct packed {
      rf_adr_t rfd_adr;
      logic    op_lsu_load;
      logic    op_mfspr;
   } ctrl_stage_t;

   typedef struct packed {
      logic  taken;
      addr_t target;
      addr_t mispredict_target;
      addr_t jal_result;
      logic  ibus_align;
   } branch_res_t;

endpackage

`default_nettype wire

//--- hw/hazard_detect.sv
// operand hazard detection for results that the bypass network cannot supply yet
`timescale 1ns/100ps
`default_nettype none

module hazard_detect (
   input  dx_pipe_pkg::dec_op_t      dec_op_i,
   input  dx_pipe_pkg::dec_operand_t dec_operand_i,
   input  logic                      op_rfe_i,
   input  dx_pipe_pkg::ctrl_stage_t  ctrl_i,
   input  dx_pipe_pkg::dec_op_t      exec_op_i,
   input  logic                      exec_rf_wb_i,
   input  or_isa_pkg::rf_adr_t       exec_rfd_adr_i,
   input  logic                      padv_i,
   output logic                      decode_bubble_o,
   output logic                      jr_pending_o
);

   logic ctrl_rfb_hit;
   logic exec_rfa_hit;
   logic exec_rfb_hit;
   logic late_result_use;
   logic atomic_store;

   // load and mfspr results only exist once the control stage is reached
   assign ctrl_rfb_hit = (ctrl_i.op_lsu_load | ctrl_i.op_mfspr) &
                         (dec_operand_i.rfb_adr == ctrl_i.rfd_adr);

   assign exec_rfa_hit = dec_operand_i.rfa_adr == exec_rfd_adr_i;
   assign exec_rfb_hit = dec_operand_i.rfb_adr == exec_rfd_adr_i;

   // jr reads rfb in decode, so any write still in flight blocks it
   assign jr_pending_o = dec_op_i.jr &
                         (ctrl_rfb_hit | (exec_rf_wb_i & exec_rfb_hit));

   assign late_result_use = (exec_op_i.lsu_load | exec_op_i.mfspr) &
                            (exec_rfa_hit | exec_rfb_hit);

   assign atomic_store = exec_op_i.lsu_store & exec_op_i.lsu_atomic;

   // rfe bubbles to hold fetch while it travels up to the control stage
   assign decode_bubble_o = padv_i &
                            (late_result_use | jr_pending_o | atomic_store | op_rfe_i);

endmodule

`default_nettype wire

//--- hw/or_isa_pkg.sv
// instruction-set level types shared by the decode and execute stages
`default_nettype none

`include "dx_cfg.svh"

package or_isa_pkg;

   // pc and operand word
   typedef logic [`DX_OPERAND_WIDTH-1:0] addr_t;

   // general purpose register number
   typedef logic [`DX_RF_ADR_WIDTH-1:0] rf_adr_t;

   // 16-bit immediate as found in the instruction word
   typedef logic [15:0] imm16_t;

   // upper 10 bits of the 26-bit jump/branch word offset
   typedef logic [9:0] immjbr_upper_t;

   // major opcode, instruction bits 31:26
   typedef logic [5:0] opc_insn_t;

   // alu operation select
   typedef logic [3:0] alu_opc_t;

   // load/store access size: byte, half, word
   typedef logic [1:0] lsu_len_t;

   // major opcode of l.nop, also what a flushed or bubbled slot carries
   localparam opc_insn_t OPC_NOP = 6'h05;

endpackage

`default_nettype wire

//--- hw/stage_register.sv
// decode-to-execute pipeline register with flush and bubble clearing
`timescale 1ns/100ps
`default_nettype none

module stage_register (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       padv_i,
   input  logic                       flush_i,
   input  or_isa_pkg::addr_t          pc_i,
   input  dx_pipe_pkg::dec_op_t       dec_op_i,
   input  dx_pipe_pkg::dec_operand_t  dec_operand_i,
   input  dx_pipe_pkg::except_t       except_i,
   input  logic                       op_rfe_i,
   input  logic                       decode_bubble_i,
   input  dx_pipe_pkg::branch_res_t   branch_i,
   input  logic                       predicted_flag_i,
   output dx_pipe_pkg::dec_op_t       exec_op_o,
   output dx_pipe_pkg::dec_operand_t  exec_operand_o,
   output dx_pipe_pkg::except_t       exec_except_o,
   output logic                       exec_op_rfe_o,
   output or_isa_pkg::addr_t          pc_execute_o,
   output or_isa_pkg::addr_t          mispredict_target_o,
   output logic                       predicted_flag_o,
   output or_isa_pkg::addr_t          jal_result_o,
   output logic                       decode_valid_o,
   output logic                       execute_bubble_o
);

   import or_isa_pkg::*;
   import dx_pipe_pkg::*;

   dec_operand_t operand_nxt;
   except_t      except_nxt;

   // a bubble keeps the fields but drops write-back, adder controls and opcode
   always_comb begin
      operand_nxt = dec_operand_i;
      if (decode_bubble_i) begin
         operand_nxt.rf_wb          = 1'b0;
         operand_nxt.adder_do_sub   = 1'b0;
         operand_nxt.adder_do_carry = 1'b0;
         operand_nxt.opc_insn       = OPC_NOP;
      end
   end

   // the alignment fault is only known once the branch is resolved
   always_comb begin
      except_nxt            = except_i;
      except_nxt.ibus_align = branch_i.ibus_align;
   end

   always_ff @(posedge clk) begin
      if (rst || flush_i) begin
         exec_op_o                     <= '0;
         exec_operand_o.rf_wb          <= 1'b0;
         exec_operand_o.adder_do_sub   <= 1'b0;
         exec_operand_o.adder_do_carry <= 1'b0;
         exec_operand_o.opc_insn       <= OPC_NOP;
         exec_op_rfe_o                 <= 1'b0;
         execute_bubble_o              <= 1'b0;
      end else if (padv_i) begin
         exec_op_o        <= decode_bubble_i ? '0 : dec_op_i;
         exec_operand_o   <= operand_nxt;
         // rfe is not bubbled, it has to reach control to take the return
         exec_op_rfe_o    <= op_rfe_i;
         execute_bubble_o <= decode_bubble_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         exec_except_o  <= '0;
         decode_valid_o <= 1'b0;
      end else begin
         decode_valid_o <= padv_i;
         if (padv_i) begin
            exec_except_o <= except_nxt;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (padv_i) begin
         pc_execute_o <= pc_i;
         jal_result_o <= branch_i.jal_result;
      end
   end

   // only conditional branches carry prediction state into execute
   always_ff @(posedge clk) begin
      if (padv_i && dec_op_i.brcond) begin
         mispredict_target_o <= branch_i.mispredict_target;
         predicted_flag_o    <= predicted_flag_i;
      end
   end

endmodule

`default_nettype wire

//--- include/dx_cfg.svh
// decode-to-execute stage configuration: datapath widths, delay slot and alignment
`ifndef DX_CFG_SVH
`define DX_CFG_SVH

// width of operands, pc and branch targets
`define DX_OPERAND_WIDTH 32

// register file address width, 32 general purpose registers
`define DX_RF_ADR_WIDTH 5

// 1 when the isa executes a delay slot after every jump or branch,
// which moves the link and fall-through pc two instructions ahead
`define DX_DELAY_SLOT 1

// low bits of a jump target that have to be zero for word alignment
`define DX_INSN_ALIGN_BITS 2

`endif

//--- test/dx_assertions.sv
// concurrent checks on the decode-to-execute register's flush, bubble and valid behavior
`timescale 1ns/100ps
`default_nettype none

module dx_assertions (
   input logic                      clk,
   input logic                      rst,
   input logic                      padv_i,
   input logic                      flush_i,
   input logic                      decode_bubble_i,
   input dx_pipe_pkg::dec_op_t      exec_op_o,
   input dx_pipe_pkg::dec_operand_t exec_operand_o,
   input logic                      decode_valid_o
);

   // a flush leaves no operation in execute
   flush_clears_ops: assert property (
      @(posedge clk) disable iff (rst) flush_i |=> (exec_op_o == '0))
      else $error("flush did not clear the execute op flags");

   bubble_clears_wb: assert property (
      @(posedge clk) disable iff (rst) (padv_i && decode_bubble_i) |=> !exec_operand_o.rf_wb)
      else $error("bubble left rf_wb set in execute");

   // valid is padv delayed by one cycle
   valid_follows_padv: assert property (
      @(posedge clk) disable iff (rst) decode_valid_o == $past(padv_i))
      else $error("decode_valid_o does not follow padv_i");

endmodule

`default_nettype wire

//--- test/tb_decode_execute.sv
// directed testbench for the decode-to-execute stage
`timescale 1ns/100ps
`default_nettype none

`include "dx_cfg.svh"

module tb_decode_execute;

   import or_isa_pkg::*;
   import dx_pipe_pkg::*;

   localparam int NUM_TESTS = 6;
   localparam int CYCLE_LIMIT = 40 * NUM_TESTS;

   logic clk = 1'b0;
   logic rst;
   logic padv, flush, op_rfe, illegal, syscall, pred_flag;
   addr_t pc, dec_rfb, exe_rfb;
   dec_op_t dec_op;
   dec_operand_t dec_opnd;
   ctrl_stage_t ctrl;

   dec_op_t exe_op;
   dec_operand_t exe_opnd;
   logic exe_rfe, exe_illegal, exe_syscall, exe_align, exe_pred, dvalid, exe_bubble;
   logic br_taken, bubble;
   addr_t pc_exe, mispredict_tgt, jal_res, br_target;

   int mismatch_count = 0;
   int cycle_count = 0;
   logic [31:0] rand_state = 32'd73;

   decode_execute u_decode_execute (
      .clk(clk), .rst(rst), .padv_i(padv), .pipeline_flush_i(flush),
      .pc_decode_i(pc), .decode_op_i(dec_op), .decode_operand_i(dec_opnd),
      .decode_op_rfe_i(op_rfe), .decode_except_illegal_i(illegal),
      .decode_except_syscall_i(syscall), .decode_rfb_i(dec_rfb), .execute_rfb_i(exe_rfb),
      .predicted_flag_i(pred_flag), .ctrl_stage_i(ctrl),
      .execute_op_o(exe_op), .execute_operand_o(exe_opnd), .execute_op_rfe_o(exe_rfe),
      .execute_except_illegal_o(exe_illegal), .execute_except_syscall_o(exe_syscall),
      .execute_except_ibus_align_o(exe_align), .pc_execute_o(pc_exe),
      .execute_mispredict_target_o(mispredict_tgt), .execute_predicted_flag_o(exe_pred),
      .execute_jal_result_o(jal_res), .decode_valid_o(dvalid),
      .execute_bubble_o(exe_bubble), .decode_branch_o(br_taken),
      .decode_branch_target_o(br_target), .decode_bubble_o(bubble)
   );

   bind stage_register dx_assertions u_dx_assertions (
      .clk(clk), .rst(rst), .padv_i(padv_i), .flush_i(flush_i),
      .decode_bubble_i(decode_bubble_i), .exec_op_o(exec_op_o),
      .exec_operand_o(exec_operand_o), .decode_valid_o(decode_valid_o)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] next_random();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return rand_state;
   endfunction

   // pc-relative target: 26-bit word offset, sign-extended
   function automatic addr_t imm_target(addr_t base, immjbr_upper_t up, imm16_t lo);
      logic [27:0] off;
      off = {up, lo, 2'b00};
      return base + {{(`DX_OPERAND_WIDTH-28){off[27]}}, off};
   endfunction

   task automatic check_op(dec_op_t got, dec_op_t exp, string msg);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
         mismatch_count++;
      end
   endtask

   task automatic check_addr(addr_t got, addr_t exp, string msg);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
         mismatch_count++;
      end
   endtask

   task automatic check_bit(logic got, logic exp, string msg);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
         mismatch_count++;
      end
   endtask

   task automatic check_opc(opc_insn_t got, opc_insn_t exp, string msg);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
         mismatch_count++;
      end
   endtask

   // called right after a rising edge
   task automatic drive_idle();
      padv <= 1'b0;
      flush <= 1'b0;
      op_rfe <= 1'b0;
      illegal <= 1'b0;
      syscall <= 1'b0;
      dec_op <= '0;
      dec_opnd <= '0;
      pred_flag <= 1'b0;
      ctrl <= '0;
   endtask

   task automatic clear_stage();
      @(posedge clk);
      drive_idle();
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
   endtask

   task automatic test_pass_hold();
      dec_op_t op_a;
      dec_operand_t opnd_a;
      addr_t pc_a;
      logic [31:0] rnd;
      logic ill_a;
      logic sys_a;
      clear_stage();
      for (int i = 0; i < 4; i++) begin
         op_a = dec_op_t'(next_random());
         // keep the random op free of hazard sources
         op_a.jr = 0;
         op_a.lsu_load = 0;
         op_a.mfspr = 0;
         op_a.lsu_atomic = 0;
         opnd_a = dec_operand_t'({next_random(), next_random(), next_random()});
         pc_a = next_random();
         rnd = next_random();
         ill_a = rnd[31];
         sys_a = rnd[30];
         dec_op <= op_a;
         dec_opnd <= opnd_a;
         pc <= pc_a;
         illegal <= ill_a;
         syscall <= sys_a;
         padv <= 1'b1;
         @(posedge clk);
         padv <= 1'b0;
         dec_op <= dec_op_t'(next_random());
         dec_opnd.immediate <= next_random();
         pc <= ~pc_a;
         illegal <= ~ill_a;
         syscall <= ~sys_a;
         @(negedge clk);
         check_op(exe_op, op_a, "loaded op");
         check_addr(exe_opnd.immediate, opnd_a.immediate, "loaded immediate");
         check_opc(exe_opnd.opc_insn, opnd_a.opc_insn, "loaded opcode");
         check_addr(pc_exe, pc_a, "loaded pc");
         check_bit(exe_illegal, ill_a, "loaded illegal");
         check_bit(exe_syscall, sys_a, "loaded syscall");
         check_bit(dvalid, 1'b1, "decode_valid after padv");
         @(posedge clk);
         @(negedge clk);
         check_op(exe_op, op_a, "held op");
         check_addr(exe_opnd.immediate, opnd_a.immediate, "held immediate");
         check_addr(pc_exe, pc_a, "held pc");
         check_bit(exe_illegal, ill_a, "held illegal");
         check_bit(exe_syscall, sys_a, "held syscall");
         check_bit(dvalid, 1'b0, "decode_valid without padv");
         @(posedge clk);
      end
   endtask

   task automatic test_flush();
      clear_stage();
      dec_op <= '{alu: 1'b1, default: 1'b0};
      dec_opnd.rf_wb <= 1'b1;
      dec_opnd.opc_insn <= 6'h38;
      padv <= 1'b1;
      @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      // a bubbling rfe under flush leaves neither a bubble nor an rfe
      op_rfe <= 1'b1;
      @(negedge clk);
      check_op(exe_op, '0, "ops after flush");
      check_bit(exe_opnd.rf_wb, 1'b0, "rf_wb after flush");
      check_opc(exe_opnd.opc_insn, OPC_NOP, "opcode after flush");
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      check_bit(exe_bubble, 1'b0, "execute_bubble after flush");
      check_bit(exe_rfe, 1'b0, "rfe after flush");
   endtask

   task automatic test_hazard();
      clear_stage();
      dec_op <= '{lsu_load: 1'b1, default: 1'b0};
      dec_opnd.rfd_adr <= 5'd7;
      dec_opnd.rf_wb <= 1'b1;
      padv <= 1'b1;
      @(posedge clk);
      dec_op <= '{alu: 1'b1, default: 1'b0};
      dec_opnd.rfd_adr <= 5'd3;
      dec_opnd.rfa_adr <= 5'd7;
      @(negedge clk);
      check_bit(bubble, 1'b1, "load-use bubble");
      @(posedge clk);
      // rfe in decode bubbles too but still reaches execute
      op_rfe <= 1'b1;
      dec_opnd.rfa_adr <= 5'd1;
      @(negedge clk);
      check_op(exe_op, '0, "ops after load-use bubble");
      check_bit(exe_bubble, 1'b1, "execute_bubble after load-use");
      check_bit(exe_opnd.rf_wb, 1'b0, "rf_wb after bubble");
      check_bit(bubble, 1'b1, "rfe bubble");
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      check_bit(exe_rfe, 1'b1, "rfe passes the bubble");
      check_bit(exe_bubble, 1'b1, "execute_bubble after rfe");
   endtask

   task automatic test_imm_branch();
      clear_stage();
      pc <= 32'h0000_1000;
      dec_op <= '{jbr: 1'b1, default: 1'b0};
      dec_opnd.immjbr_upper <= 10'h3FF;
      dec_opnd.imm16 <= 16'hFFFC;
      dec_opnd.opc_insn <= 6'h00;
      padv <= 1'b1;
      @(negedge clk);
      check_bit(br_taken, 1'b1, "l.j taken");
      check_addr(br_target, imm_target(32'h1000, 10'h3FF, 16'hFFFC), "l.j target");
      @(posedge clk);
      padv <= 1'b0;
      dec_opnd.opc_insn <= 6'h04;
      @(negedge clk);
      check_bit(exe_align, 1'b0, "aligned target");
      check_bit(br_taken, 1'b0, "bf not taken with flag clear");
      @(posedge clk);
      pred_flag <= 1'b1;
      @(negedge clk);
      check_bit(br_taken, 1'b1, "bf taken with flag set");
      @(posedge clk);
      dec_opnd.opc_insn <= 6'h03;
      @(negedge clk);
      check_bit(br_taken, 1'b0, "bnf not taken with flag set");
      @(posedge clk);
      pred_flag <= 1'b0;
      @(negedge clk);
      check_bit(br_taken, 1'b1, "bnf taken with flag clear");
      @(posedge clk);
      pc <= 32'h0000_1002;
      padv <= 1'b1;
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      check_bit(exe_align, 1'b1, "misaligned target");
   endtask

   task automatic test_reg_branch();
      addr_t val_d, val_e;
      val_d = next_random() & 32'hFFFF_FFFC;
      val_e = next_random() & 32'hFFFF_FFFC;
      clear_stage();
      dec_op <= '{alu: 1'b1, default: 1'b0};
      dec_opnd.rfd_adr <= 5'd9;
      dec_opnd.rf_wb <= 1'b1;
      padv <= 1'b1;
      @(posedge clk);
      dec_op <= '{jr: 1'b1, default: 1'b0};
      dec_opnd.rfb_adr <= 5'd9;
      dec_opnd.rf_wb <= 1'b0;
      dec_rfb <= val_d;
      exe_rfb <= val_e;
      @(negedge clk);
      check_bit(br_taken, 1'b0, "jr with pending rfb");
      check_bit(bubble, 1'b1, "jr pending bubble");
      @(posedge clk);
      padv <= 1'b0;
      @(negedge clk);
      check_bit(br_taken, 1'b1, "jr after bubble");
      check_addr(br_target, val_e, "jr target after bubble");
      clear_stage();
      dec_op <= '{jr: 1'b1, default: 1'b0};
      dec_opnd.rfb_adr <= 5'd9;
      // a load in the control stage still owes rfb
      ctrl <= '{rfd_adr: 5'd9, op_lsu_load: 1'b1, op_mfspr: 1'b0};
      @(negedge clk);
      check_bit(br_taken, 1'b0, "jr with load pending in control");
      @(posedge clk);
      ctrl <= '0;
      @(negedge clk);
      check_bit(br_taken, 1'b1, "jr without dependence");
      check_addr(br_target, val_d, "jr target from decode");
   endtask

   task automatic test_mispredict_link();
      clear_stage();
      pc <= 32'h0000_2000;
      dec_op <= '{jbr: 1'b1, bf: 1'b1, brcond: 1'b1, default: 1'b0};
      dec_opnd.imm16 <= 16'h0010;
      dec_opnd.opc_insn <= 6'h04;
      padv <= 1'b1;
      @(posedge clk);
      pred_flag <= 1'b1;
      @(negedge clk);
      check_addr(mispredict_tgt, imm_target(32'h2000, 10'h000, 16'h0010), "bf mispredict");
      check_bit(exe_pred, 1'b0, "predicted flag clear");
      check_addr(jal_res, 32'h0000_2008, "link after bf");
      @(posedge clk);
      pc <= 32'h0000_3000;
      dec_op <= '{jbr: 1'b1, jal: 1'b1, default: 1'b0};
      dec_opnd.opc_insn <= 6'h01;
      @(negedge clk);
      check_addr(mispredict_tgt, 32'h0000_2008, "bf predicted taken, next pc");
      check_bit(exe_pred, 1'b1, "predicted flag set");
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      check_addr(jal_res, 32'h0000_3008, "jal link");
      check_addr(mispredict_tgt, 32'h0000_2008, "mispredict target held");
   endtask

   initial begin
      rst = 1'b1;
      padv = 1'b0;
      flush = 1'b0;
      op_rfe = 1'b0;
      illegal = 1'b0;
      syscall = 1'b0;
      pred_flag = 1'b0;
      pc = '0;
      dec_rfb = '0;
      exe_rfb = '0;
      dec_op = '0;
      dec_opnd = '0;
      ctrl = '0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      test_pass_hold();
      test_flush();
      test_hazard();
      test_imm_branch();
      test_reg_branch();
      test_mispredict_link();
      @(posedge clk);
      $display("errors: %0d mismatches", mismatch_count);
      if (mismatch_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
